// File: testbench/boot_trace.txt
# op value exp_a exp_b, hex fields
# R: table word to preload, expected boot_page, expected table_valid
# W: page to write, expected stored word, expected page on read back
# C: as W, with random reads while the write runs
R B3A5 1 1
R 97FF 1 1
R DBC0 2 1
R 0123 2 0
R FC12 0 1
R AAAA 0 0
R B000 1 1
W 2 D800 2
W 1 B000 1
W 0 FC00 0
W 3 FC00 0
R 9400 1 1
C 2 D800 2
C 0 FC00 0
C 1 B000 1
C 3 FC00 0

// File: sim.f
verilog/flash_pkg.sv
verilog/flash_cmd_if.sv
verilog/bus_cycle_engine.sv
verilog/bus_arbiter.sv
verilog/table_reader.sv
verilog/table_writer.sv
verilog/flash_boot_ctrl.sv
testbench/flash_model.sv
testbench/tb_flash_boot_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the boot-table testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_flash_boot_ctrl \
    -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# the log decides the result
if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: testbench/tb_flash_boot_ctrl.sv
`timescale 1ns/100ps

module tb_flash_boot_ctrl;

    localparam int WAIT_CYCLES   = 16;
    localparam int READ_TIMEOUT  = 200;
    localparam int WRITE_TIMEOUT = 4000;

    logic             clk;
    logic             rst_n;
    logic             rd_req;
    logic             wr_req;
    flash_pkg::page_t wr_page;
    logic             preload_en;
    flash_pkg::data_t preload_word;

    flash_pkg::data_t flash_dq_in;
    flash_pkg::addr_t flash_addr;
    flash_pkg::data_t flash_dq_out;
    logic             flash_dq_oe;
    logic             flash_ce_n;
    logic             flash_oe_n;
    logic             flash_we_n;
    logic             flash_adv_n;
    logic             rd_done;
    logic             wr_done;
    flash_pkg::page_t boot_page;
    logic             table_valid;

    // lcg state for the random reads
    logic [31:0]      rnd;
    // page the reader should hold now
    flash_pkg::page_t last_page;

    flash_boot_ctrl #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) flash_boot_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .wr_page      (wr_page),
        .flash_dq_in  (flash_dq_in),
        .flash_addr   (flash_addr),
        .flash_dq_out (flash_dq_out),
        .flash_dq_oe  (flash_dq_oe),
        .flash_ce_n   (flash_ce_n),
        .flash_oe_n   (flash_oe_n),
        .flash_we_n   (flash_we_n),
        .flash_adv_n  (flash_adv_n),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .boot_page    (boot_page),
        .table_valid  (table_valid)
    );

    flash_model flash_model_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .preload_en   (preload_en),
        .preload_word (preload_word),
        .flash_addr   (flash_addr),
        .flash_dq_out (flash_dq_out),
        .flash_dq_oe  (flash_dq_oe),
        .flash_ce_n   (flash_ce_n),
        .flash_oe_n   (flash_oe_n),
        .flash_we_n   (flash_we_n),
        .flash_dq_in  (flash_dq_in)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual));
        end
    endtask

    // pulse rd_req, then wait for rd_done to fall and rise again
    task automatic run_read(input int line_no);
        int cycles;
        @(posedge clk);
        rd_req <= 1'b1;
        @(posedge clk);
        rd_req <= 1'b0;
        cycles = 0;
        while (rd_done) begin
            @(posedge clk);
            cycles++;
            if (cycles > READ_TIMEOUT) begin
                fail_run($sformatf("timeout, rd_done never dropped on line %0d", line_no));
            end
        end
        cycles = 0;
        while (!rd_done) begin
            @(posedge clk);
            cycles++;
            if (cycles > READ_TIMEOUT) begin
                fail_run($sformatf("timeout, read on line %0d never finished", line_no));
            end
        end
    endtask

    task automatic read_line(input int line_no, input flash_pkg::data_t word,
                             input flash_pkg::page_t exp_page, input logic exp_valid);
        @(posedge clk);
        preload_en   <= 1'b1;
        preload_word <= word;
        @(posedge clk);
        preload_en <= 1'b0;
        run_read(line_no);
        check_equal($sformatf("line %0d read boot_page", line_no), 32'(exp_page),
                    32'(boot_page));
        check_equal($sformatf("line %0d read table_valid", line_no), 32'(exp_valid),
                    32'(table_valid));
        // unknown codes keep the page, the trace says so too
        last_page = exp_page;
    endtask

    // --------------------
    // write, optionally with random reads
    // --------------------
    task automatic write_line(input int line_no, input flash_pkg::page_t page,
                              input flash_pkg::data_t exp_word,
                              input flash_pkg::page_t exp_page, input logic with_reads);
        flash_pkg::data_t seq [6];
        int               cycles;
        int               log_start;
        int               reads;
        int               wr_phase;
        int               rd_phase;
        logic             ok;
        logic [5:0]       idx;
        seq[0] = 16'h0060;
        seq[1] = 16'h00D0;
        seq[2] = 16'h0020;
        seq[3] = 16'h00D0;
        seq[4] = 16'h0040;
        seq[5] = exp_word;
        log_start = flash_model_inst.log_cnt;
        @(posedge clk);
        wr_req  <= 1'b1;
        wr_page <= page;
        @(posedge clk);
        wr_req <= 1'b0;
        cycles   = 0;
        reads    = 0;
        wr_phase = 0;
        rd_phase = 0;
        while (wr_phase != 2 || rd_phase != 0) begin
            @(posedge clk);
            rd_req <= 1'b0;
            cycles++;
            if (cycles > WRITE_TIMEOUT) begin
                fail_run($sformatf("timeout, write on line %0d never finished", line_no));
            end
            // wr_done falls on accept, rises at the end
            if (wr_phase == 0 && !wr_done) begin
                wr_phase = 1;
            end else if (wr_phase == 1 && wr_done) begin
                wr_phase = 2;
            end
            if (rd_phase == 0 && with_reads && wr_phase != 2) begin
                rnd = lcg_next(rnd);
                if (rnd[18:16] == 3'd0) begin
                    rd_req <= 1'b1;
                    rd_phase = 1;
                end
            end else if (rd_phase == 1 && !rd_done) begin
                rd_phase = 2;
            end else if (rd_phase == 2 && rd_done) begin
                // old word, erased word or new word
                ok = (boot_page == last_page) || (boot_page == 2'd0) ||
                     (boot_page == exp_page);
                check_equal($sformatf("line %0d read during write page", line_no), 32'd1,
                            32'(ok));
                check_equal($sformatf("line %0d read during write table_valid", line_no),
                            32'd1, 32'(table_valid));
                // read got the bus in between the write commands
                if (wr_phase == 1) begin
                    reads++;
                end
                rd_phase = 0;
            end
        end
        if (with_reads) begin
            check_equal($sformatf("line %0d reads finished during write", line_no), 32'd1,
                        32'(reads > 0));
        end
        // six bus writes, all at the table word
        check_equal($sformatf("line %0d log count", line_no), 32'(log_start + 6),
                    32'(flash_model_inst.log_cnt));
        for (int k = 0; k < 6; k++) begin
            idx = 6'(log_start + k);
            check_equal($sformatf("line %0d log %0d address", line_no, k),
                        32'(flash_pkg::TABLE_ADDR), 32'(flash_model_inst.log_addr[idx]));
            check_equal($sformatf("line %0d log %0d data", line_no, k), 32'(seq[k]),
                        32'(flash_model_inst.log_data[idx]));
        end
        check_equal($sformatf("line %0d stored word", line_no), 32'(exp_word),
                    32'(flash_model_inst.table_word));
        // read back the page just written
        run_read(line_no);
        check_equal($sformatf("line %0d read back boot_page", line_no), 32'(exp_page),
                    32'(boot_page));
        check_equal($sformatf("line %0d read back table_valid", line_no), 32'd1,
                    32'(table_valid));
        last_page = exp_page;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [7:0]  op;
        logic [31:0] val;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        rst_n        <= 1'b0;
        rd_req       <= 1'b0;
        wr_req       <= 1'b0;
        wr_page      <= '0;
        preload_en   <= 1'b0;
        preload_word <= '0;
        rnd       = 32'd79;
        last_page = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // idle bus and flags after reset
        check_equal("reset ce_n", 32'd1, 32'(flash_ce_n));
        check_equal("reset oe_n", 32'd1, 32'(flash_oe_n));
        check_equal("reset we_n", 32'd1, 32'(flash_we_n));
        check_equal("reset adv_n", 32'd1, 32'(flash_adv_n));
        check_equal("reset dq_oe", 32'd0, 32'(flash_dq_oe));
        check_equal("reset rd_done", 32'd0, 32'(rd_done));
        check_equal("reset wr_done", 32'd0, 32'(wr_done));
        check_equal("reset table_valid", 32'd0, 32'(table_valid));
        fd = $fopen("testbench/boot_trace.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the trace file testbench/boot_trace.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            // skip blank and comment lines
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, val, exp_a, exp_b);
                if (n != 4) begin
                    fail_run($sformatf("trace line %0d cannot be parsed", line_no));
                end
                case (op)
                    "R": read_line(line_no, val[15:0], exp_a[1:0], exp_b[0]);
                    "W": write_line(line_no, val[1:0], exp_a[15:0], exp_b[1:0], 1'b0);
                    "C": write_line(line_no, val[1:0], exp_a[15:0], exp_b[1:0], 1'b1);
                    default: fail_run($sformatf("trace line %0d has an unknown operation",
                                                line_no));
                endcase
            end
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: testbench/flash_model.sv
`timescale 1ns/100ps

module flash_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             preload_en,
    input  flash_pkg::data_t preload_word,
    input  flash_pkg::addr_t flash_addr,
    input  flash_pkg::data_t flash_dq_out,
    input  logic             flash_dq_oe,
    input  logic             flash_ce_n,
    input  logic             flash_oe_n,
    input  logic             flash_we_n,
    output flash_pkg::data_t flash_dq_in
);

    // the table word, only word this model stores
    flash_pkg::data_t table_word;
    // first byte of a two-write command
    logic [7:0]       pending;
    logic             we_q;
    // chip enable and data drive while we_n was still low
    logic             ce_q;
    logic             dq_oe_q;

    // --------------------
    // write log
    // --------------------
    // one (address, data) pair per we_n rising edge
    flash_pkg::addr_t log_addr [64];
    flash_pkg::data_t log_data [64];
    int               log_cnt;
    logic [5:0]       log_idx;

    assign log_idx = log_cnt[5:0];

    // flash drives the bus only while selected and oe_n is low
    assign flash_dq_in = (!flash_ce_n && !flash_oe_n &&
                          flash_addr == flash_pkg::TABLE_ADDR) ? table_word : 16'hFFFF;

    always @(posedge clk) begin
        if (!rst_n) begin
            table_word <= 16'hFFFF;
            pending    <= 8'h00;
            we_q       <= 1'b1;
            ce_q       <= 1'b1;
            dq_oe_q    <= 1'b0;
            log_cnt    <= 0;
        end else begin
            we_q    <= flash_we_n;
            ce_q    <= flash_ce_n;
            dq_oe_q <= flash_dq_oe;
            if (preload_en) begin
                table_word <= preload_word;
                pending    <= 8'h00;
            end else if (!we_q && flash_we_n && !ce_q && dq_oe_q) begin
                // rising edge of we_n, seen one clock later
                // only taken with the chip selected and data driven
                log_addr[log_idx] <= flash_addr;
                log_data[log_idx] <= flash_dq_out;
                log_cnt           <= log_cnt + 1;
                if (flash_addr == flash_pkg::TABLE_ADDR) begin
                    if (pending == flash_pkg::CMD_PROGRAM) begin
                        // program only clears bits
                        table_word <= table_word & flash_dq_out;
                        pending    <= 8'h00;
                    end else if (pending == flash_pkg::CMD_ERASE &&
                                 flash_dq_out[7:0] == flash_pkg::CMD_CONFIRM) begin
                        table_word <= 16'hFFFF;
                        pending    <= 8'h00;
                    end else if (pending == flash_pkg::CMD_UNLOCK &&
                                 flash_dq_out[7:0] == flash_pkg::CMD_CONFIRM) begin
                        // block unlocked, nothing stored
                        pending <= 8'h00;
                    end else begin
                        pending <= flash_dq_out[7:0];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/flash_boot_ctrl.sv
`timescale 1ns/100ps

module flash_boot_ctrl #(
    parameter int WAIT_CYCLES = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rd_req,
    input  logic             wr_req,
    input  flash_pkg::page_t wr_page,
    input  flash_pkg::data_t flash_dq_in,
    output flash_pkg::addr_t flash_addr,
    output flash_pkg::data_t flash_dq_out,
    output logic             flash_dq_oe,
    output logic             flash_ce_n,
    output logic             flash_oe_n,
    output logic             flash_we_n,
    output logic             flash_adv_n,
    output logic             rd_done,
    output logic             wr_done,
    output flash_pkg::page_t boot_page,
    output logic             table_valid
);

    // peer links and the engine link
    flash_cmd_if rd_if ();
    flash_cmd_if wr_if ();
    flash_cmd_if eng_if ();

    // --------------------
    // peers
    // --------------------
    table_reader table_reader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_req      (rd_req),
        .bus         (rd_if.master),
        .rd_done     (rd_done),
        .boot_page   (boot_page),
        .table_valid (table_valid)
    );

    table_writer #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) table_writer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_page (wr_page),
        .bus     (wr_if.master),
        .wr_done (wr_done)
    );

    // --------------------
    // shared bus
    // --------------------
    bus_arbiter bus_arbiter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_bus  (rd_if.slave),
        .wr_bus  (wr_if.slave),
        .eng_bus (eng_if.master)
    );

    bus_cycle_engine bus_cycle_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (eng_if.slave),
        .flash_dq_in  (flash_dq_in),
        .flash_addr   (flash_addr),
        .flash_dq_out (flash_dq_out),
        .flash_dq_oe  (flash_dq_oe),
        .flash_ce_n   (flash_ce_n),
        .flash_oe_n   (flash_oe_n),
        .flash_we_n   (flash_we_n),
        .flash_adv_n  (flash_adv_n)
    );

endmodule

// File: verilog/table_writer.sv
`timescale 1ns/100ps

module table_writer #(
    parameter int WAIT_CYCLES = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_req,
    input  flash_pkg::page_t wr_page,
    flash_cmd_if.master      bus,
    output logic             wr_done
);

    localparam int CNT_W = $clog2(WAIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES - 1);

    flash_pkg::writer_state_e state;
    flash_pkg::writer_state_e cmd_next;
    logic                     credit_held;
    logic [CNT_W-1:0]         wait_cnt;
    logic [5:0]               page_code;
    flash_pkg::data_t         cmd_word;

    // every command hits the table word
    assign bus.cmd_write = 1'b1;
    assign bus.cmd_addr  = flash_pkg::TABLE_ADDR;

    // word and successor of each command state
    always_comb begin
        cmd_word = '0;
        cmd_next = flash_pkg::W_IDLE;
        case (state)
            flash_pkg::W_UNLOCK_1: begin
                cmd_word = {8'h00, flash_pkg::CMD_UNLOCK};
                cmd_next = flash_pkg::W_UNLOCK_2;
            end
            flash_pkg::W_UNLOCK_2: begin
                cmd_word = {8'h00, flash_pkg::CMD_CONFIRM};
                cmd_next = flash_pkg::W_ERASE_1;
            end
            flash_pkg::W_ERASE_1: begin
                cmd_word = {8'h00, flash_pkg::CMD_ERASE};
                cmd_next = flash_pkg::W_ERASE_2;
            end
            flash_pkg::W_ERASE_2: begin
                cmd_word = {8'h00, flash_pkg::CMD_CONFIRM};
                cmd_next = flash_pkg::W_ERASE_WAIT;
            end
            flash_pkg::W_PROGRAM_1: begin
                cmd_word = {8'h00, flash_pkg::CMD_PROGRAM};
                cmd_next = flash_pkg::W_PROGRAM_2;
            end
            flash_pkg::W_PROGRAM_2: begin
                // code word, zeros below the code
                cmd_word = {page_code, 10'b0};
                cmd_next = flash_pkg::W_PROGRAM_WAIT;
            end
            default: ;
        endcase
    end

    // --------------------
    // sequence FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= flash_pkg::W_IDLE;
            credit_held   <= 1'b1;
            wait_cnt      <= '0;
            wr_done       <= 1'b0;
            bus.cmd_valid <= 1'b0;
        end else begin
            bus.cmd_valid <= 1'b0;
            case (state)
                flash_pkg::W_IDLE: begin
                    if (wr_req) begin
                        wr_done <= 1'b0;
                        state   <= flash_pkg::W_UNLOCK_1;
                    end
                end
                flash_pkg::W_ERASE_WAIT: begin
                    if (wait_cnt == WAIT_LAST) begin
                        wait_cnt <= '0;
                        state    <= flash_pkg::W_PROGRAM_1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                flash_pkg::W_PROGRAM_WAIT: begin
                    if (wait_cnt == WAIT_LAST) begin
                        wait_cnt <= '0;
                        state    <= flash_pkg::W_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                flash_pkg::W_DONE: begin
                    wr_done <= 1'b1;
                    state   <= flash_pkg::W_IDLE;
                end
                default: begin
                    // command states: send once, then wait for the credit
                    if (credit_held) begin
                        bus.cmd_valid <= 1'b1;
                        credit_held   <= 1'b0;
                    end
                    if (bus.credit) begin
                        credit_held <= 1'b1;
                        state       <= cmd_next;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        bus.cmd_wdata <= cmd_word;
        // page 3 has no code of its own, stored as page 0
        if (state == flash_pkg::W_IDLE && wr_req) begin
            case (wr_page)
                2'd1:    page_code <= flash_pkg::CODE_PAGE1;
                2'd2:    page_code <= flash_pkg::CODE_PAGE2;
                default: page_code <= flash_pkg::CODE_PAGE0;
            endcase
        end
    end

    // commands only come out of the six command states
    a_cmd_in_cmd_state: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cmd_valid |-> state inside {flash_pkg::W_UNLOCK_1, flash_pkg::W_UNLOCK_2,
                                        flash_pkg::W_ERASE_1, flash_pkg::W_ERASE_2,
                                        flash_pkg::W_PROGRAM_1, flash_pkg::W_PROGRAM_2});

endmodule

// File: verilog/table_reader.sv
`timescale 1ns/100ps

module table_reader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_req,
    flash_cmd_if.master        bus,
    output logic               rd_done,
    output flash_pkg::page_t   boot_page,
    output logic               table_valid
);

    logic       credit_held;
    logic [5:0] code;

    // always one read of the table word
    assign bus.cmd_write = 1'b0;
    assign bus.cmd_addr  = flash_pkg::TABLE_ADDR;
    assign bus.cmd_wdata = '0;

    // page code sits in the top six bits
    assign code = bus.rdata[15:10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_held   <= 1'b1;
            bus.cmd_valid <= 1'b0;
            rd_done       <= 1'b0;
            boot_page     <= '0;
            table_valid   <= 1'b0;
        end else begin
            bus.cmd_valid <= 1'b0;
            // no credit means a read is still running
            if (rd_req && credit_held) begin
                bus.cmd_valid <= 1'b1;
                credit_held   <= 1'b0;
                rd_done       <= 1'b0;
            end
            if (bus.credit) begin
                credit_held <= 1'b1;
                rd_done     <= 1'b1;
                table_valid <= 1'b1;
                case (code)
                    flash_pkg::CODE_PAGE0:     boot_page <= 2'd0;
                    flash_pkg::CODE_PAGE1,
                    flash_pkg::CODE_PAGE1_ALT: boot_page <= 2'd1;
                    flash_pkg::CODE_PAGE2:     boot_page <= 2'd2;
                    // unknown code, keep the old page
                    default:                   table_valid <= 1'b0;
                endcase
            end
        end
    end

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    flash_cmd_if.slave  rd_bus,
    flash_cmd_if.slave  wr_bus,
    flash_cmd_if.master eng_bus
);

    // slot index 0 is the reader, 1 the writer
    logic [1:0]       in_valid;
    logic [1:0]       in_write;
    flash_pkg::addr_t in_addr [2];
    flash_pkg::data_t in_wdata [2];

    logic [1:0]       slot_full;
    logic [1:0]       slot_write;
    flash_pkg::addr_t slot_addr [2];
    flash_pkg::data_t slot_wdata [2];

    logic             eng_credit;
    // peer that owns the cycle now on the bus
    logic             owner;
    logic             pick;
    logic             fwd;

    always_comb begin
        in_valid    = {wr_bus.cmd_valid, rd_bus.cmd_valid};
        in_write    = {wr_bus.cmd_write, rd_bus.cmd_write};
        in_addr[0]  = rd_bus.cmd_addr;
        in_addr[1]  = wr_bus.cmd_addr;
        in_wdata[0] = rd_bus.cmd_wdata;
        in_wdata[1] = wr_bus.cmd_wdata;
    end

    // reader wins a tie
    assign pick = !slot_full[0];
    assign fwd  = eng_credit && (|slot_full);

    // --------------------
    // slots and credit
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_full         <= '0;
            eng_credit        <= 1'b1;
            owner             <= 1'b0;
            eng_bus.cmd_valid <= 1'b0;
        end else begin
            eng_bus.cmd_valid <= 1'b0;
            if (eng_bus.credit) begin
                eng_credit <= 1'b1;
            end
            if (fwd) begin
                eng_bus.cmd_valid <= 1'b1;
                eng_credit        <= 1'b0;
                owner             <= pick;
                slot_full[pick]   <= 1'b0;
            end
            // a peer only sends into an empty slot
            for (int i = 0; i < 2; i++) begin
                if (in_valid[i]) begin
                    slot_full[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (in_valid[i]) begin
                slot_write[i] <= in_write[i];
                slot_addr[i]  <= in_addr[i];
                slot_wdata[i] <= in_wdata[i];
            end
        end
        if (fwd) begin
            eng_bus.cmd_write <= slot_write[pick];
            eng_bus.cmd_addr  <= slot_addr[pick];
            eng_bus.cmd_wdata <= slot_wdata[pick];
        end
    end

    // credit and read data go back to the owner only
    assign rd_bus.credit = eng_bus.credit && !owner;
    assign wr_bus.credit = eng_bus.credit && owner;
    assign rd_bus.rdata  = eng_bus.rdata;
    assign wr_bus.rdata  = eng_bus.rdata;

    // forward only with the engine credit in hand
    a_fwd_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        eng_bus.cmd_valid |-> $past(eng_credit) && !eng_credit);

    // engine returns only a credit that was spent
    a_credit_spent: assert property (@(posedge clk) disable iff (!rst_n)
        eng_bus.credit |-> !eng_credit);

endmodule

// File: verilog/bus_cycle_engine.sv
`timescale 1ns/100ps

module bus_cycle_engine (
    input  logic             clk,
    input  logic             rst_n,
    flash_cmd_if.slave       bus,
    input  flash_pkg::data_t flash_dq_in,
    output flash_pkg::addr_t flash_addr,
    output flash_pkg::data_t flash_dq_out,
    output logic             flash_dq_oe,
    output logic             flash_ce_n,
    output logic             flash_oe_n,
    output logic             flash_we_n,
    output logic             flash_adv_n
);

    localparam int STEP_W = $clog2(flash_pkg::CYCLE_LEN);

    // named steps of one bus cycle
    localparam logic [STEP_W-1:0] STEP_ADDR   = STEP_W'(0);
    localparam logic [STEP_W-1:0] STEP_ADV    = STEP_W'(1);
    localparam logic [STEP_W-1:0] STEP_STROBE = STEP_W'(2);
    localparam logic [STEP_W-1:0] STEP_DATA   = STEP_W'(3);
    localparam logic [STEP_W-1:0] STEP_SAMPLE = STEP_W'(flash_pkg::SAMPLE_STEP);
    localparam logic [STEP_W-1:0] STEP_LAST   = STEP_W'(flash_pkg::CYCLE_LEN - 1);

    logic              busy;
    logic [STEP_W-1:0] step;

    // latched command
    logic              cyc_write;
    flash_pkg::addr_t  cyc_addr;
    flash_pkg::data_t  cyc_wdata;

    // --------------------
    // step counter and strobes
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            step        <= '0;
            flash_ce_n  <= 1'b1;
            flash_oe_n  <= 1'b1;
            flash_we_n  <= 1'b1;
            flash_adv_n <= 1'b1;
            flash_dq_oe <= 1'b0;
            bus.credit  <= 1'b0;
        end else begin
            bus.credit <= 1'b0;
            if (!busy) begin
                // new cycle starts at step 0
                if (bus.cmd_valid) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else begin
                step <= step + 1'b1;
                case (step)
                    STEP_ADDR: begin
                        flash_adv_n <= 1'b1;
                    end
                    STEP_ADV: begin
                        flash_adv_n <= 1'b0;
                        flash_ce_n  <= 1'b0;
                    end
                    STEP_STROBE: begin
                        flash_adv_n <= 1'b1;
                        if (cyc_write) begin
                            flash_we_n <= 1'b0;
                        end else begin
                            flash_oe_n <= 1'b0;
                        end
                    end
                    STEP_DATA: begin
                        // drive data only on writes
                        flash_dq_oe <= cyc_write;
                    end
                    STEP_LAST: begin
                        flash_ce_n  <= 1'b1;
                        flash_oe_n  <= 1'b1;
                        flash_we_n  <= 1'b1;
                        flash_dq_oe <= 1'b0;
                        // hand the credit back, engine free again
                        bus.credit  <= 1'b1;
                        busy        <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // --------------------
    // address, data, capture
    // --------------------
    always_ff @(posedge clk) begin
        if (!busy && bus.cmd_valid) begin
            cyc_write <= bus.cmd_write;
            cyc_addr  <= bus.cmd_addr;
            cyc_wdata <= bus.cmd_wdata;
        end
        if (busy && step == STEP_ADDR) begin
            flash_addr <= cyc_addr;
        end
        if (busy && step == STEP_DATA) begin
            flash_dq_out <= cyc_wdata;
        end
        // sample late, flash output has settled by now
        if (busy && step == STEP_SAMPLE) begin
            bus.rdata <= flash_dq_in;
        end
    end

    // bus contention with the flash outputs
    a_no_contention: assert property (@(posedge clk) disable iff (!rst_n)
        !(flash_dq_oe && !flash_oe_n));

    // arbiter must not send without the credit
    a_cmd_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cmd_valid |-> !busy);

endmodule

// File: verilog/flash_cmd_if.sv
`timescale 1ns/100ps

interface flash_cmd_if;

    // command, one-clock pulse, only sent while holding the credit
    logic             cmd_valid;
    logic             cmd_write;
    flash_pkg::addr_t cmd_addr;
    flash_pkg::data_t cmd_wdata;

    // credit comes back when the bus cycle is over
    logic             credit;
    // read data, valid together with credit
    flash_pkg::data_t rdata;

    modport master (
        output cmd_valid, cmd_write, cmd_addr, cmd_wdata,
        input  credit, rdata
    );

    modport slave (
        input  cmd_valid, cmd_write, cmd_addr, cmd_wdata,
        output credit, rdata
    );

endinterface

// File: verilog/flash_pkg.sv
package flash_pkg;

    // --------------------
    // bus widths
    // --------------------
    // word address, A25..A1
    typedef logic [25:1] addr_t;
    typedef logic [15:0] data_t;
    // boot page for the remote-update loader
    typedef logic [1:0]  page_t;

    // boot table lives in one word
    localparam addr_t TABLE_ADDR = 25'h0008000;

    // async bus cycle shape
    localparam int CYCLE_LEN   = 8;
    // read data is stable by this step
    localparam int SAMPLE_STEP = 6;

    // --------------------
    // flash commands
    // --------------------
    typedef enum logic [7:0] {
        CMD_ERASE   = 8'h20,
        CMD_PROGRAM = 8'h40,
        CMD_UNLOCK  = 8'h60,
        CMD_CONFIRM = 8'hD0
    } flash_op_e;

    // page codes in table bits 15:10
    localparam logic [5:0] CODE_PAGE0     = 6'b111111;
    localparam logic [5:0] CODE_PAGE1     = 6'b101100;
    // older images use this one for page 1
    localparam logic [5:0] CODE_PAGE1_ALT = 6'b100101;
    localparam logic [5:0] CODE_PAGE2     = 6'b110110;

    // table write sequence
    typedef enum logic [3:0] {
        W_IDLE,
        W_UNLOCK_1,
        W_UNLOCK_2,
        W_ERASE_1,
        W_ERASE_2,
        W_ERASE_WAIT,
        W_PROGRAM_1,
        W_PROGRAM_2,
        W_PROGRAM_WAIT,
        W_DONE
    } writer_state_e;

endpackage
